//--- dv/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model (
	input  logic sd_clock,
	input  logic dat_out,
	input  logic dat_oe,
	output logic dat_in
);

	logic [31:0] card_mem [64];  // loaded by the testbench
	int          wr_ptr;
	int          blocks_rx;
	int          reject_blk;      // 1-based block to reject, 0 for none
	int          line_errs;       // framing faults and drive conflicts
	int          seed = 32'h168c;
	logic        cap;
	int          bit_cnt;
	logic [31:0] shreg;
	logic [2:0]  tok_val;
	event        tok_ev;

	initial
	begin
		cap = 1'b0;
		wr_ptr = 0;
		blocks_rx = 0;
		reject_blk = 0;
		line_errs = 0;
	end

	// write block capture, msb first
	always @(posedge sd_clock)
	begin
		if (dat_oe && !dat_in)
		begin
			line_errs = line_errs + 1;
			$display("host drives the data line while the card sends");
		end
		if (!cap)
		begin
			if (dat_oe && !dat_out)
			begin
				cap = 1'b1;
				bit_cnt = 0;
			end
		end
		else if (bit_cnt == 128)
		begin
			cap = 1'b0;  // end bit
			if (!dat_oe || !dat_out)
			begin
				line_errs = line_errs + 1;
				$display("write block has no high end bit");
			end
			blocks_rx = blocks_rx + 1;
			tok_val = (blocks_rx == reject_blk) ? 3'b101 : 3'b010;
			-> tok_ev;
		end
		else
		begin
			if (!dat_oe)
			begin
				line_errs = line_errs + 1;
				$display("host released the data line inside a write block");
			end
			shreg = {shreg[30:0], dat_out};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt % 32 == 0)
			begin
				card_mem[wr_ptr % 64] = shreg;
				wr_ptr = wr_ptr + 1;
			end
		end
	end

	// token reply after 1 to 8 idle cycles
	initial
	begin
		logic [4:0] bits;
		dat_in = 1'b1;
		forever
		begin
			@(tok_ev);
			bits = {1'b0, tok_val, 1'b1};
			repeat (1 + ($random(seed) & 7)) @(negedge sd_clock);
			for (int i = 4; i >= 0; i--)
			begin
				dat_in = bits[i];
				@(negedge sd_clock);
			end
		end
	end

	task automatic send_blocks(input int nb);
		int          idx;
		logic [31:0] word;
		idx = 0;
		for (int b = 0; b < nb; b++)
		begin
			repeat (4 + ($random(seed) & 7)) @(negedge sd_clock);
			dat_in = 1'b0;  // start bit
			@(negedge sd_clock);
			for (int w = 0; w < 4; w++)
			begin
				word = card_mem[idx % 64];
				idx++;
				for (int k = 31; k >= 0; k--)
				begin
					dat_in = word[k];
					@(negedge sd_clock);
				end
			end
			dat_in = 1'b1;
			@(negedge sd_clock);
		end
	endtask

endmodule

//--- dv/tb_sd_dat.sv
`timescale 1ns/1ps
`include "sd_dat_config.svh"

module tb_sd_dat;
	import sd_host_pkg::*;
	import sd_buf_pkg::*;

	localparam int N_XFERS = 7;
	localparam int LIMIT = N_XFERS * (15 * (130 + `SD_TIMEOUT_CYCLES + 16)) + 2000;

	logic         sd_clock;
	logic         reset;
	xfer_cmd_t    cmd;
	logic         cmd_valid;
	logic         cmd_ready;
	xfer_status_t status;
	logic         status_valid;
	logic         status_ready;
	buf_req_t     host_req;
	logic         host_valid;
	logic         host_ready;
	buf_rsp_t     host_rsp;
	logic         dat_out;
	logic         dat_oe;
	logic         dat_in;

	int          seed = 32'h168c;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	logic [31:0] buf_mirror [64];
	logic [31:0] card_mirror [64];

	sd_dat_top UUT (.*);

	sd_card_model u_card (
		.sd_clock (sd_clock),
		.dat_out  (dat_out),
		.dat_oe   (dat_oe),
		.dat_in   (dat_in)
	);

	always #2 sd_clock = ~sd_clock;

	always @(posedge sd_clock)
	begin
		cycles++;
		if (cycles >= LIMIT)
		begin
			$display("timeout: no end of test after %0d cycles", LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic int pick(input int lo, input int hi);
		return lo + (($random(seed) & 32'h7fffffff) % (hi - lo + 1));
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input xfer_status_t exp,
		input xfer_status_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("[ERROR] %s expected %s/%0d actual %s/%0d", name,
				exp.code.name(), exp.done_blocks, act.code.name(), act.done_blocks);
		end
	endtask

	task automatic host_write(input logic [5:0] a, input logic [31:0] d);
		@(negedge sd_clock);
		host_req = '{we: 1'b1, addr: a, wdata: d};
		host_valid = 1'b1;
		while (!host_ready)
			@(negedge sd_clock);
		@(negedge sd_clock);
		host_valid = 1'b0;
	endtask

	task automatic host_read(input logic [5:0] a, output logic [31:0] d);
		@(negedge sd_clock);
		host_req = '{we: 1'b0, addr: a, wdata: '0};
		host_valid = 1'b1;
		while (!host_ready)
			@(negedge sd_clock);
		@(negedge sd_clock);
		host_valid = 1'b0;
		d = host_rsp.rdata;  // registered one cycle after the grant
	endtask

	task automatic verify_buffer(input string name);
		logic [31:0] d;
		for (int i = 0; i < 64; i++)
		begin
			host_read(6'(i), d);
			check_word(name, buf_mirror[i], d);
		end
	endtask

	task automatic issue_cmd(input xfer_op_e op, input int base, input int nb, input logic tmo);
		@(negedge sd_clock);
		cmd = '{op: op, base: 6'(base), blocks: 4'(nb), timeout_en: tmo};
		cmd_valid = 1'b1;
		while (!cmd_ready)
			@(negedge sd_clock);
		@(negedge sd_clock);
		cmd_valid = 1'b0;
	endtask

	// back-pressure on status, then take it
	task automatic take_status(output xfer_status_t st);
		xfer_status_t held;
		while (!status_valid)
			@(negedge sd_clock);
		held = status;
		repeat (pick(0, 7))
		begin
			@(negedge sd_clock);
			if (!status_valid || status !== held)
			begin
				errors++;
				$display("status changed or dropped while the host held it off");
			end
			if (cmd_ready)
			begin
				errors++;
				$display("cmd_ready went high while status was pending");
			end
		end
		status_ready = 1'b1;
		@(negedge sd_clock);
		status_ready = 1'b0;
		st = held;
	endtask

	task automatic run_write(input int base, input int nb, input int rej);
		xfer_status_t st;
		xfer_status_t exp;
		int           sent;
		u_card.wr_ptr = 0;
		u_card.blocks_rx = 0;
		u_card.reject_blk = rej;
		u_card.line_errs = 0;
		issue_cmd(XFER_WRITE, base, nb, pick(0, 1));
		take_status(st);
		sent = (rej != 0 && rej <= nb) ? rej : nb;
		exp.code = (sent == nb && rej != nb) ? XFER_OK : XFER_REJECT;
		exp.done_blocks = 4'((exp.code == XFER_OK) ? nb : rej - 1);
		check_status("write status", exp, st);
		check_word("write blocks at card", sent, u_card.blocks_rx);
		check_word("write line faults at card", 0, u_card.line_errs);
		for (int i = 0; i < sent * 4; i++)
		begin
			check_word("write data at card", buf_mirror[6'(base + i)], u_card.card_mem[i]);
			card_mirror[i] = buf_mirror[6'(base + i)];
		end
	endtask

	task automatic run_read(input int base, input int nb, input logic hang);
		xfer_status_t st;
		xfer_status_t exp;
		logic [5:0]   a;
		logic [31:0]  d;
		u_card.line_errs = 0;
		issue_cmd(XFER_READ, base, nb, hang ? 1'b1 : 1'(pick(0, 1)));
		fork
			begin
				if (!hang)
					u_card.send_blocks(nb);
			end
			begin
				// host traffic outside the block range
				for (int j = 0; j < 3; j++)
				begin
					a = 6'(base + nb * 4 + pick(0, 63 - nb * 4));
					d = $random(seed);
					host_write(a, d);
					buf_mirror[a] = d;
				end
			end
		join
		take_status(st);
		exp.code = hang ? XFER_TIMEOUT : XFER_OK;
		exp.done_blocks = hang ? 4'd0 : 4'(nb);
		check_status(hang ? "hung read status" : "read status", exp, st);
		check_word("read line faults at card", 0, u_card.line_errs);
		if (!hang)
			for (int i = 0; i < nb * 4; i++)
				buf_mirror[6'(base + i)] = card_mirror[i];
		verify_buffer("read buffer contents");
	endtask

	initial
	begin
		logic [31:0] d;
		int          nb;
		sd_clock = 1'b0;
		reset = 1'b1;
		cmd = '0;
		cmd_valid = 1'b0;
		status_ready = 1'b0;
		host_req = '0;
		host_valid = 1'b0;
		repeat (2) @(posedge sd_clock);
		@(negedge sd_clock);
		reset = 1'b0;
		for (int i = 0; i < 64; i++)
		begin
			card_mirror[i] = $random(seed);
			u_card.card_mem[i] = card_mirror[i];
		end
		for (int i = 0; i < 64; i++)
		begin
			buf_mirror[i] = $random(seed);
			host_write(6'(i), buf_mirror[i]);
		end
		repeat (20)
		begin
			int a;
			a = pick(0, 63);
			host_read(6'(a), d);
			check_word("host readback", buf_mirror[a], d);
		end
		run_write(pick(0, 63), pick(1, 15), 0);
		run_write(pick(0, 63), pick(1, 15), 0);
		nb = pick(2, 15);
		run_write(pick(0, 63), nb, pick(1, nb));
		repeat (3)
			run_read(pick(0, 63), pick(1, 15), 1'b0);
		run_read(pick(0, 63), pick(1, 15), 1'b1);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- logic/block_buffer.sv
`timescale 1ns/1ps
`include "sd_dat_config.svh"

module block_buffer (
	input  logic                 sd_clock,
	input  logic                 reset,
	input  logic                 en,
	input  sd_buf_pkg::buf_req_t req,
	output sd_buf_pkg::buf_rsp_t rsp
);

	logic [31:0] mem [`SD_BUF_DEPTH];

	always_ff @(posedge sd_clock)
	begin
		if (en && req.we)
			mem[req.addr] <= req.wdata;
	end

	// registered read port
	always_ff @(posedge sd_clock)
	begin
		if (reset)
			rsp.rdata <= '0;
		else if (en && !req.we)
			rsp.rdata <= mem[req.addr];
	end

endmodule

//--- logic/buf_arbiter.sv
`timescale 1ns/1ps

module buf_arbiter (
	input  logic                 sd_clock,
	input  logic                 reset,
	input  sd_buf_pkg::buf_req_t ctl_req,
	input  logic                 ctl_valid,
	output logic                 ctl_ready,
	output sd_buf_pkg::buf_rsp_t ctl_rsp,
	input  sd_buf_pkg::buf_req_t host_req,
	input  logic                 host_valid,
	output logic                 host_ready,
	output sd_buf_pkg::buf_rsp_t host_rsp,
	output logic                 mem_en,
	output sd_buf_pkg::buf_req_t mem_req,
	input  sd_buf_pkg::buf_rsp_t mem_rsp
);

	logic arb_on;     // low for the first cycle out of reset
	logic ctl_gnt;
	logic host_gnt;
	logic ctl_rd_q;
	logic host_rd_q;

	// controller always wins
	assign ctl_ready = arb_on;
	assign host_ready = arb_on && !ctl_valid;

	assign ctl_gnt = ctl_valid && ctl_ready;
	assign host_gnt = host_valid && host_ready;

	assign mem_en = ctl_gnt || host_gnt;
	assign mem_req = ctl_gnt ? ctl_req : host_req;

	assign ctl_rsp.rdata = ctl_rd_q ? mem_rsp.rdata : '0;
	assign host_rsp.rdata = host_rd_q ? mem_rsp.rdata : '0;

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			arb_on <= 1'b0;
			ctl_rd_q <= 1'b0;
			host_rd_q <= 1'b0;
		end
		else
		begin
			arb_on <= 1'b1;
			ctl_rd_q <= ctl_gnt && !ctl_req.we;    // owner of next rdata
			host_rd_q <= host_gnt && !host_req.we;
		end
	end

	// exclusive grants, and the controller lets go the next cycle so the host gets through
	assert property (@(posedge sd_clock) disable iff (reset)
		ctl_gnt |-> !host_gnt ##1 !ctl_gnt);

endmodule

//--- logic/dat_phys_controller.sv
`timescale 1ns/1ps
`include "sd_dat_config.svh"

module dat_phys_controller (
	input  logic                      sd_clock,
	input  logic                      reset,
	input  sd_host_pkg::xfer_cmd_t    cmd,
	input  logic                      cmd_valid,
	output logic                      cmd_ready,
	output sd_host_pkg::xfer_status_t status,
	output logic                      status_valid,
	input  logic                      status_ready,
	output sd_buf_pkg::buf_req_t      ctl_req,
	output logic                      ctl_valid,
	input  logic                      ctl_ready,
	input  sd_buf_pkg::buf_rsp_t      ctl_rsp,
	output sd_host_pkg::ser_op_e      ser_op,
	output logic [31:0]               ser_word,
	output logic                      ser_valid,
	input  logic                      ser_ready,
	input  logic                      ser_done,
	input  logic [31:0]               ser_rx_word,
	input  logic [2:0]                ser_token,
	input  logic                      ser_timeout,
	output logic                      timeout_en
);
	import sd_host_pkg::*;

	localparam int AW = $clog2(`SD_BUF_DEPTH);
	localparam int WW = $clog2(`SD_BLOCK_WORDS);
	localparam logic [WW-1:0] LAST_WORD = WW'(`SD_BLOCK_WORDS - 1);
	localparam logic [2:0] TOKEN_OK = 3'b010;

	typedef enum logic [3:0] {
		IDLE,
		LOAD_WORD,
		SEND_START,
		SEND_WORD,
		SEND_END,
		WAIT_TOKEN,
		READ_WORD,
		STORE_WORD,
		WAIT_ACK
	} phys_state_e;

	phys_state_e   state;
	xfer_code_e    code_q;
	logic [AW-1:0] addr_q;
	logic [WW-1:0] word_cnt;
	logic [3:0]    blk_cnt;    // good blocks so far
	logic [3:0]    blk_total;
	logic          tmo_en_q;
	logic          rsp_pending;
	logic          issued;     // receive op handed to the framer
	logic [31:0]   word_q;
	logic [31:0]   rx_q;
	logic          ser_fire;
	logic          ctl_fire;
	logic          done_seen;
	logic          last_word;
	logic          last_blk;

	assign ser_fire = ser_valid && ser_ready;
	assign ctl_fire = ctl_valid && ctl_ready;
	assign done_seen = issued && ser_done;
	assign last_word = (word_cnt == LAST_WORD);
	assign last_blk = (blk_cnt + 4'd1 == blk_total);

	assign ser_word = word_q;
	assign timeout_en = tmo_en_q;
	assign status_valid = (state == WAIT_ACK);
	assign status = '{code: code_q, done_blocks: blk_cnt};

	always_comb
	begin
		ctl_valid = 1'b0;
		ctl_req = '{we: 1'b0, addr: addr_q, wdata: rx_q};
		ser_valid = 1'b0;
		ser_op = SER_SEND_WORD;
		case (state)
			LOAD_WORD: ctl_valid = 1'b1;
			STORE_WORD:
			begin
				ctl_valid = 1'b1;
				ctl_req.we = 1'b1;
			end
			SEND_START:
			begin
				ser_valid = 1'b1;
				ser_op = SER_SEND_START;
			end
			SEND_WORD: ser_valid = !rsp_pending;  // wait for the prefetched word
			SEND_END:
			begin
				ser_valid = 1'b1;
				ser_op = SER_SEND_END;
			end
			WAIT_TOKEN:
			begin
				ser_valid = !issued;
				ser_op = SER_RECV_TOKEN;
			end
			READ_WORD:
			begin
				// next word of the block is asked for on the done cycle
				ser_valid = !issued || (done_seen && !ser_timeout && !last_word);
				ser_op = SER_RECV_WORD;
			end
			default: ;
		endcase
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			state <= IDLE;
			cmd_ready <= 1'b0;
			code_q <= XFER_OK;
			addr_q <= '0;
			word_cnt <= '0;
			blk_cnt <= '0;
			blk_total <= '0;
			tmo_en_q <= 1'b0;
			rsp_pending <= 1'b0;
			issued <= 1'b0;
		end
		else
		begin
			rsp_pending <= 1'b0;
			cmd_ready <= 1'b0;
			case (state)
				IDLE:
					if (cmd_valid && cmd_ready)
					begin
						addr_q <= cmd.base;
						word_cnt <= '0;
						blk_cnt <= '0;
						blk_total <= (cmd.blocks == 4'd0) ? 4'd1 : cmd.blocks;
						tmo_en_q <= cmd.timeout_en;
						code_q <= XFER_OK;
						issued <= 1'b0;
						state <= (cmd.op == XFER_WRITE) ? LOAD_WORD : READ_WORD;
					end
					else
						cmd_ready <= 1'b1;
				LOAD_WORD:
					if (ctl_fire)
					begin
						addr_q <= addr_q + 1'b1;  // wraps with the buffer
						rsp_pending <= 1'b1;
						state <= (word_cnt == '0) ? SEND_START : SEND_WORD;
					end
				SEND_START:
					if (ser_fire)
						state <= SEND_WORD;
				SEND_WORD:
					if (ser_fire)
					begin
						word_cnt <= last_word ? '0 : word_cnt + 1'b1;
						state <= last_word ? SEND_END : LOAD_WORD;
					end
				SEND_END:
					if (ser_fire)
						state <= WAIT_TOKEN;
				WAIT_TOKEN:
				begin
					if (ser_fire)
						issued <= 1'b1;
					if (done_seen)
					begin
						issued <= 1'b0;
						if (ser_timeout)
						begin
							code_q <= XFER_TIMEOUT;
							state <= WAIT_ACK;
						end
						else if (ser_token != TOKEN_OK)
						begin
							code_q <= XFER_REJECT;
							state <= WAIT_ACK;
						end
						else
						begin
							blk_cnt <= blk_cnt + 1'b1;
							state <= last_blk ? WAIT_ACK : LOAD_WORD;
						end
					end
				end
				READ_WORD:
				begin
					if (ser_fire)
						issued <= 1'b1;
					if (done_seen)
					begin
						if (ser_timeout)
							code_q <= XFER_TIMEOUT;
						state <= ser_timeout ? WAIT_ACK : STORE_WORD;
					end
				end
				STORE_WORD:
					if (ctl_fire)
					begin
						addr_q <= addr_q + 1'b1;
						if (last_word)
						begin
							word_cnt <= '0;
							blk_cnt <= blk_cnt + 1'b1;
							issued <= 1'b0;  // next block hunts for its start bit
							state <= last_blk ? WAIT_ACK : READ_WORD;
						end
						else
						begin
							word_cnt <= word_cnt + 1'b1;
							state <= READ_WORD;
						end
					end
				WAIT_ACK:
					if (status_ready)
					begin
						cmd_ready <= 1'b1;
						state <= IDLE;
					end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (rsp_pending)
			word_q <= ctl_rsp.rdata;
		if (state == READ_WORD && done_seen)
			rx_q <= ser_rx_word;
	end

	// status held until the host takes it
	assert property (@(posedge sd_clock) disable iff (reset)
		status_valid && !status_ready |=> status_valid && $stable(status));

endmodule

//--- logic/dat_serializer.sv
`timescale 1ns/1ps
`include "sd_dat_config.svh"

module dat_serializer (
	input  logic                 sd_clock,
	input  logic                 reset,
	input  sd_host_pkg::ser_op_e ser_op,
	input  logic [31:0]          ser_word,
	input  logic                 ser_valid,
	output logic                 ser_ready,
	input  logic                 timeout_en,
	output logic                 ser_done,
	output logic [31:0]          ser_rx_word,
	output logic [2:0]           ser_token,
	output logic                 ser_timeout,
	output logic                 dat_out,
	output logic                 dat_oe,
	input  logic                 dat_in
);
	import sd_host_pkg::*;

	localparam int TW = $clog2(`SD_TIMEOUT_CYCLES + 1);

	logic          busy;
	logic          rx;
	logic          hunt;      // waiting for a start bit
	logic          in_frame;  // start bit already seen, words follow back to back
	logic          tmo_on;
	logic [5:0]    cnt;
	logic [5:0]    rx_bits;
	logic [TW-1:0] tmo;
	logic [31:0]   shift;
	logic          accept;
	logic          rx_op;

	assign ser_ready = !busy;
	assign accept = ser_valid && ser_ready;
	assign rx_op = ser_op inside {SER_RECV_WORD, SER_RECV_TOKEN};
	assign rx_bits = (ser_op == SER_RECV_TOKEN) ? 6'd3 : 6'd32;
	assign ser_rx_word = shift;
	assign ser_token = shift[2:0];

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			rx <= 1'b0;
			hunt <= 1'b0;
			in_frame <= 1'b0;
			tmo_on <= 1'b0;
			cnt <= '0;
			tmo <= '0;
			ser_done <= 1'b0;
			ser_timeout <= 1'b0;
			dat_out <= 1'b1;
			dat_oe <= 1'b0;
		end
		else
		begin
			ser_done <= 1'b0;
			ser_timeout <= 1'b0;
			if (accept)
			begin
				case (ser_op)
					SER_SEND_WORD:
					begin
						dat_oe <= 1'b1;
						dat_out <= ser_word[31];  // msb first
						cnt <= 6'd31;
						busy <= 1'b1;
						rx <= 1'b0;
						in_frame <= 1'b0;
					end
					SER_SEND_START, SER_SEND_END:
					begin
						dat_oe <= 1'b1;
						dat_out <= (ser_op == SER_SEND_END);
						ser_done <= 1'b1;
						in_frame <= 1'b0;
					end
					default:
					begin
						dat_oe <= 1'b0;
						dat_out <= 1'b1;
						busy <= 1'b1;
						rx <= 1'b1;
						tmo_on <= timeout_en;
						tmo <= TW'(`SD_TIMEOUT_CYCLES);
						hunt <= !in_frame;
						// inside a frame the first bit is sampled right now
						cnt <= in_frame ? rx_bits - 6'd1 : rx_bits;
					end
				endcase
			end
			else if (!busy)
			begin
				dat_oe <= 1'b0;
				dat_out <= 1'b1;
				in_frame <= 1'b0;  // frame over once nobody asks for more
			end
			else if (!rx)
			begin
				dat_out <= shift[31];
				cnt <= cnt - 6'd1;
				if (cnt == 6'd1)
				begin
					busy <= 1'b0;
					ser_done <= 1'b1;
				end
			end
			else if (hunt)
			begin
				if (!dat_in)
				begin
					hunt <= 1'b0;
					in_frame <= 1'b1;
				end
				else if (tmo_on)
				begin
					tmo <= tmo - 1'b1;
					if (tmo == TW'(1))
					begin
						busy <= 1'b0;
						hunt <= 1'b0;
						ser_done <= 1'b1;
						ser_timeout <= 1'b1;
					end
				end
			end
			else
			begin
				cnt <= cnt - 6'd1;
				if (cnt == 6'd1)
				begin
					busy <= 1'b0;
					ser_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (accept && ser_op == SER_SEND_WORD)
			shift <= {ser_word[30:0], 1'b1};
		else if (accept && rx_op && in_frame)
			shift <= {shift[30:0], dat_in};
		else if (busy && (!rx || !hunt))
			shift <= {shift[30:0], rx ? dat_in : 1'b1};
	end

	// a word owns the line for 32 cycles, nothing else is taken meanwhile
	assert property (@(posedge sd_clock) disable iff (reset)
		accept && ser_op == SER_SEND_WORD
		|=> (!ser_ready && dat_oe) [*31] ##1 (ser_ready && ser_done));

endmodule

//--- logic/sd_buf_pkg.sv
`include "sd_dat_config.svh"

package sd_buf_pkg;

	typedef struct packed {
		logic                             we;
		logic [$clog2(`SD_BUF_DEPTH)-1:0] addr;
		logic [31:0]                      wdata;
	} buf_req_t;

	// read data, one cycle after the request
	typedef struct packed {
		logic [31:0] rdata;
	} buf_rsp_t;

endpackage

//--- logic/sd_dat_config.svh
`ifndef SD_DAT_CONFIG_SVH
`define SD_DAT_CONFIG_SVH

// shared block buffer, in 32-bit words
`define SD_BUF_DEPTH 64

// words per data block on the line
`define SD_BLOCK_WORDS 4

// cycles to wait for a start bit or token
`define SD_TIMEOUT_CYCLES 300

`endif

//--- logic/sd_dat_top.sv
`timescale 1ns/1ps

module sd_dat_top (
	input  logic                      sd_clock,
	input  logic                      reset,
	input  sd_host_pkg::xfer_cmd_t    cmd,
	input  logic                      cmd_valid,
	output logic                      cmd_ready,
	output sd_host_pkg::xfer_status_t status,
	output logic                      status_valid,
	input  logic                      status_ready,
	input  sd_buf_pkg::buf_req_t      host_req,
	input  logic                      host_valid,
	output logic                      host_ready,
	output sd_buf_pkg::buf_rsp_t      host_rsp,
	output logic                      dat_out,
	output logic                      dat_oe,
	input  logic                      dat_in
);
	import sd_host_pkg::*;
	import sd_buf_pkg::*;

	// controller side of the buffer
	buf_req_t ctl_req;
	logic     ctl_valid;
	logic     ctl_ready;
	buf_rsp_t ctl_rsp;

	// controller to framer
	ser_op_e     ser_op;
	logic [31:0] ser_word;
	logic        ser_valid;
	logic        ser_ready;
	logic        ser_done;
	logic [31:0] ser_rx_word;
	logic [2:0]  ser_token;
	logic        ser_timeout;
	logic        timeout_en;

	logic     mem_en;
	buf_req_t mem_req;
	buf_rsp_t mem_rsp;

	dat_phys_controller u_ctl (.*);

	dat_serializer u_ser (.*);

	buf_arbiter u_arb (.*);

	block_buffer u_buf (
		.sd_clock (sd_clock),
		.reset    (reset),
		.en       (mem_en),
		.req      (mem_req),
		.rsp      (mem_rsp)
	);

endmodule

//--- logic/sd_host_pkg.sv
`include "sd_dat_config.svh"

package sd_host_pkg;

	typedef enum logic {
		XFER_WRITE,
		XFER_READ
	} xfer_op_e;

	typedef struct packed {
		xfer_op_e                         op;
		logic [$clog2(`SD_BUF_DEPTH)-1:0] base;       // first buffer word
		logic [3:0]                       blocks;     // 0 means 1
		logic                             timeout_en;
	} xfer_cmd_t;

	typedef enum logic [1:0] {
		XFER_OK,
		XFER_REJECT,
		XFER_TIMEOUT
	} xfer_code_e;

	typedef struct packed {
		xfer_code_e code;
		logic [3:0] done_blocks;
	} xfer_status_t;

	// requests from the controller to the line framer
	typedef enum logic [2:0] {
		SER_SEND_WORD,
		SER_SEND_START,
		SER_SEND_END,
		SER_RECV_WORD,
		SER_RECV_TOKEN
	} ser_op_e;

endpackage

//--- tb.f
+incdir+logic
logic/sd_host_pkg.sv
logic/sd_buf_pkg.sv
logic/block_buffer.sv
logic/buf_arbiter.sv
logic/dat_serializer.sv
logic/dat_phys_controller.sv
logic/sd_dat_top.sv
dv/sd_card_model.sv
dv/tb_sd_dat.sv
